/* ppu_lite.f */
+incdir+logic
logic/ppu_pkg.sv
logic/ppu_dot_timing.sv
logic/ppu_host_regs.sv
logic/ppu_vram_access.sv
logic/ppu_palette.sv
logic/ppu_top.sv
test/ppu_tb.sv

/* test/ppu_testdata.txt */
# op addr data expected, all hex; W write, R read, V wait for vblank
# C checks state, data 0 memory byte at addr, 1 RGB of colour expected, 2 host_nmi
# Consecutive data writes, step 1
W 6 21 00
W 6 08 00
W 7 A5 00
W 7 3C 00
W 7 C3 00
C 2108 0 A5
C 2109 0 3C
C 210A 0 C3
# Step 32 with the increment bit set
W 0 04 00
W 6 22 00
W 6 00 00
W 7 11 00
W 7 22 00
W 7 33 00
C 2200 0 11
C 2220 0 22
C 2240 0 33
# Buffered reads, first one is stale
W 0 00 00
W 6 21 00
W 6 08 00
R 7 00 00
R 7 00 A5
R 7 00 3C
R 7 00 C3
# Status read clears the write toggle
W 6 21 00
R 2 00 01
W 6 21 00
W 6 0C 00
W 7 5A 00
C 210C 0 5A
# Palette with mirroring and latch bits
W 6 3F 00
W 6 10 00
W 7 2A 00
C 0000 1 2A
W 6 3F 00
W 6 00 00
W 0 80 00
R 7 00 AA
W 6 3F 00
W 6 14 00
W 7 15 00
W 6 3F 00
W 6 04 00
R 7 00 15
W 6 3F 00
W 6 00 00
W 7 21 00
C 0000 1 21
# Vertical blank, status and NMI
W 0 80 00
R 4 00 80
C 0000 2 01
V 0 00 00
C 0000 2 00
R 2 00 80
C 0000 2 01
R 2 00 00

/* test/ppu_tb.sv */
`timescale 1ns/1ps

module ppu_tb;

  import ppu_pkg::*;

  localparam int CLOCK_PERIOD   = 100;
  localparam int CLOCK_DIV_BITS = 2;
  localparam int DOT_CYCLES     = 1 << CLOCK_DIV_BITS;
  localparam int LINE_CYCLES    = 341 * DOT_CYCLES;
  localparam int FRAME_CYCLES   = 262 * LINE_CYCLES;

  // Reference RGB for each colour number
  localparam logic [23:0] RGB_REF [0:63] = '{
    24'h666666, 24'h002a88, 24'h1412a7, 24'h3b00a4, 24'h5c007e, 24'h6e0040, 24'h6c0600, 24'h561d00,
    24'h333500, 24'h0b4800, 24'h005200, 24'h004f08, 24'h00404d, 24'h000000, 24'h000000, 24'h000000,
    24'hadadad, 24'h155fd9, 24'h4240ff, 24'h7527fe, 24'ha01acc, 24'hb71e7b, 24'hb53120, 24'h994e00,
    24'h6b6d00, 24'h388700, 24'h0c9300, 24'h008f32, 24'h007c8d, 24'h000000, 24'h000000, 24'h000000,
    24'hfffeff, 24'h64b0ff, 24'h9290ff, 24'hc676ff, 24'hf36aff, 24'hfe6ecc, 24'hfe8170, 24'hea9e22,
    24'hbcbe00, 24'h88d800, 24'h5ce430, 24'h45e082, 24'h48cdde, 24'h4f4f4f, 24'h000000, 24'h000000,
    24'hfffeff, 24'hc0dfff, 24'hd3d2ff, 24'he8c8ff, 24'hfbc2ff, 24'hfec4ea, 24'hfeccc5, 24'hf7d8a5,
    24'he4e594, 24'hcfef96, 24'hbdf4ab, 24'hb3f3cc, 24'hb5ebf2, 24'hb8b8b8, 24'h000000, 24'h000000
  };

  logic       I_clock;
  logic       I_reset;
  logic       vid_clock;
  logic       vid_rise;
  logic       vid_active;
  logic       vid_hsync;
  logic       vid_vsync;
  color_t     vid_red;
  color_t     vid_green;
  color_t     vid_blue;
  host_addr_t host_addr;
  host_data_t host_data_in;
  logic       host_wren;
  logic       host_rden;
  host_data_t host_data_out;
  logic       host_nmi;
  vram_addr_t vid_addr;
  logic       vid_wren;
  host_data_t vid_data_in;
  host_data_t vid_data_out;

  logic [7:0]  vram [0:16383];  // 16 K video memory model
  int          checks;
  int          errors;
  int          timeouts;
  logic        timed_out;
  int unsigned seed_value;

  ppu_top #(
    .CLOCK_DIV_BITS (CLOCK_DIV_BITS)
  ) dut (
    .I_clock       (I_clock),
    .I_reset       (I_reset),
    .vid_clock     (vid_clock),
    .vid_rise      (vid_rise),
    .vid_active    (vid_active),
    .vid_hsync     (vid_hsync),
    .vid_vsync     (vid_vsync),
    .vid_red       (vid_red),
    .vid_green     (vid_green),
    .vid_blue      (vid_blue),
    .host_addr     (host_addr),
    .host_data_in  (host_data_in),
    .host_wren     (host_wren),
    .host_rden     (host_rden),
    .host_data_out (host_data_out),
    .host_nmi      (host_nmi),
    .vid_addr      (vid_addr),
    .vid_wren      (vid_wren),
    .vid_data_in   (vid_data_in),
    .vid_data_out  (vid_data_out)
  );

  initial I_clock = 1'b0;
  always #(CLOCK_PERIOD / 2) I_clock = ~I_clock;

  //////////////////////////////////////////////////
  // Video memory model
  //////////////////////////////////////////////////

  assign vid_data_in = vram[vid_addr];  // Asynchronous read

  always @(posedge I_clock)
  begin
    if (vid_wren)
      vram[vid_addr] <= vid_data_out;
  end

  task automatic fill_vram();
    int          i;
    logic [13:0] addr;
    for (i = 0; i < 16384; i++)
    begin
      addr       = 14'(i);
      vram[addr] = 8'($urandom) ^ addr[7:0] ^ {2'b00, addr[13:8]};
    end
  endtask

  //////////////////////////////////////////////////
  // Checks and waits
  //////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("[FAIL] %0t ns: %s, expected %0h, got %0h", $time, what, expected, actual);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out while waiting for %s", what);
    timeouts++;
    timed_out = 1'b1;
  endtask

  task automatic wait_hsync(input logic level);
    int cycles;
    cycles = 0;
    while (!timed_out && vid_hsync !== level)
    begin
      @(negedge I_clock);
      cycles++;
      if (cycles > 2 * LINE_CYCLES)
        report_timeout("a horizontal sync edge");
    end
  endtask

  task automatic wait_vblank();
    int cycles;
    cycles = 0;
    while (!timed_out && vid_vsync !== 1'b0)  // Vsync starts one line into vblank
    begin
      @(negedge I_clock);
      cycles++;
      if (cycles > 2 * FRAME_CYCLES)
        report_timeout("vertical blank");
    end
  endtask

  // Measures one line from the end of one hsync to the end of the next
  task automatic measure_line();
    int   dots;
    int   active_dots;
    int   sync_dots;
    int   clock_rises;
    int   cycles;
    logic last_clock;
    dots        = 0;
    active_dots = 0;
    sync_dots   = 0;
    clock_rises = 0;
    cycles      = 0;
    wait_hsync(1'b0);
    wait_hsync(1'b1);
    last_clock = vid_clock;
    while (!timed_out && !(sync_dots > 0 && vid_hsync === 1'b1))
    begin
      if (vid_clock === 1'b1 && last_clock === 1'b0)
        clock_rises++;
      last_clock = vid_clock;
      if (vid_rise === 1'b1)
      begin
        dots++;
        if (vid_active === 1'b1)
          active_dots++;
        if (vid_hsync === 1'b0)
          sync_dots++;
      end
      @(negedge I_clock);
      cycles++;
      if (cycles > 2 * LINE_CYCLES)
        report_timeout("the end of a line");
    end
    if (!timed_out)
    begin
      check_value("dots per line", dots, 341);
      check_value("active dots per line", active_dots, 256);
      check_value("hsync dots per line", sync_dots, 26);
      check_value("dot clock rises per line", clock_rises, 341);
      check_value("clock cycles per line", cycles, LINE_CYCLES);
    end
  endtask

  //////////////////////////////////////////////////
  // Host accesses and command player
  //////////////////////////////////////////////////

  task automatic host_write(input host_addr_t addr, input host_data_t data);
    host_addr    = addr;
    host_data_in = data;
    host_wren    = 1'b1;
    repeat (8) @(negedge I_clock);
    host_wren = 1'b0;
    repeat (8) @(negedge I_clock);
  endtask

  // Data is sampled before the edge that reloads the read buffer
  task automatic host_read(input host_addr_t addr, input host_data_t expected);
    host_addr = addr;
    host_rden = 1'b1;
    #(CLOCK_PERIOD / 4);
    check_value($sformatf("read of register %0d", addr), host_data_out, expected);
    repeat (8) @(negedge I_clock);
    host_rden = 1'b0;
    repeat (8) @(negedge I_clock);
  endtask

  // Kind 0 is a memory byte, 1 the RGB output, 2 the NMI line
  task automatic check_state(input logic [13:0] addr, input logic [1:0] kind,
                             input logic [7:0] expected);
    logic [23:0] rgb;
    rgb = RGB_REF[expected[5:0]];
    case (kind)
      2'd0: check_value($sformatf("VRAM byte at %04h", addr), vram[addr], expected);
      2'd1:
      begin
        check_value("vid_red", vid_red, rgb[23:16]);
        check_value("vid_green", vid_green, rgb[15:8]);
        check_value("vid_blue", vid_blue, rgb[7:0]);
      end
      default: check_value("host_nmi", host_nmi, expected[0]);
    endcase
  endtask

  task automatic run_command(input logic [7:0] op, input logic [15:0] addr,
                             input logic [15:0] data, input logic [15:0] expected);
    case (op)
      "W": host_write(addr[2:0], data[7:0]);
      "R": host_read(addr[2:0], expected[7:0]);
      "V": wait_vblank();
      "C": check_state(addr[13:0], data[1:0], expected[7:0]);
      default:
      begin
        $display("Unknown operation %c in the stimulus file", op);
        errors++;
      end
    endcase
  endtask

  task automatic play_commands();
    int              fd;
    int              rc;
    logic [8*16-1:0] op_token;
    logic [8*128-1:0] line_buf;
    logic [15:0]     f_addr;
    logic [15:0]     f_data;
    logic [15:0]     f_expect;
    fd = $fopen("test/ppu_testdata.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the stimulus file test/ppu_testdata.txt");
      errors++;
    end
    else
    begin
      while (!timed_out && $fscanf(fd, "%s", op_token) == 1)
      begin
        if (op_token == "#")
          rc = $fgets(line_buf, fd);  // Skip comment line
        else
        begin
          rc = $fscanf(fd, "%h %h %h", f_addr, f_data, f_expect);
          if (rc != 3)
          begin
            $display("Malformed stimulus line after operation %0s", op_token);
            errors++;
          end
          else
            run_command(op_token[7:0], f_addr, f_data, f_expect);
        end
      end
      $fclose(fd);
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial
  begin
    seed_value   = $urandom(19547);
    checks       = 0;
    errors       = 0;
    timeouts     = 0;
    timed_out    = 1'b0;
    I_reset      = 1'b0;
    host_addr    = '0;
    host_data_in = '0;
    host_wren    = 1'b0;
    host_rden    = 1'b0;
    fill_vram();
    repeat (16) @(negedge I_clock);
    I_reset = 1'b1;
    measure_line();
    if (!timed_out)
      play_commands();
    $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

/* logic/ppu_top.sv */
`timescale 1ns/1ps

module ppu_top #(
  parameter int CLOCK_DIV_BITS = 2
) (
  input  logic                I_clock,
  input  logic                I_reset,
  output logic                vid_clock,
  output logic                vid_rise,
  output logic                vid_active,
  output logic                vid_hsync,
  output logic                vid_vsync,
  output ppu_pkg::color_t     vid_red,
  output ppu_pkg::color_t     vid_green,
  output ppu_pkg::color_t     vid_blue,
  input  ppu_pkg::host_addr_t host_addr,
  input  ppu_pkg::host_data_t host_data_in,
  input  logic                host_wren,
  input  logic                host_rden,
  output ppu_pkg::host_data_t host_data_out,
  output logic                host_nmi,
  output ppu_pkg::vram_addr_t vid_addr,
  output logic                vid_wren,
  input  ppu_pkg::host_data_t vid_data_in,
  output ppu_pkg::host_data_t vid_data_out
);

  import ppu_pkg::*;

  raster_count_t  count_x;
  raster_count_t  count_y;
  logic           addr_write;
  logic           data_write;
  logic           data_read;
  logic           toggle_clear;
  logic           increment_across;
  logic           palette_write;
  logic           palette_access;
  host_data_t     read_buffer;
  palette_index_t palette_addr;
  color_index_t   palette_data;

  ppu_dot_timing #(
    .CLOCK_DIV_BITS (CLOCK_DIV_BITS)
  ) u_dot_timing (
    .I_clock    (I_clock),
    .I_reset    (I_reset),
    .vid_clock  (vid_clock),
    .vid_rise   (vid_rise),
    .vid_active (vid_active),
    .vid_hsync  (vid_hsync),
    .vid_vsync  (vid_vsync),
    .count_x    (count_x),
    .count_y    (count_y)
  );

  ppu_host_regs u_host_regs (
    .I_clock          (I_clock),
    .I_reset          (I_reset),
    .host_addr        (host_addr),
    .host_data_in     (host_data_in),
    .host_wren        (host_wren),
    .host_rden        (host_rden),
    .dot_tick         (vid_rise),  // Status flag follows the dot rate
    .count_x          (count_x),
    .count_y          (count_y),
    .palette_access   (palette_access),
    .read_buffer      (read_buffer),
    .palette_data     (palette_data),
    .host_data_out    (host_data_out),
    .host_nmi         (host_nmi),
    .addr_write       (addr_write),
    .data_write       (data_write),
    .data_read        (data_read),
    .toggle_clear     (toggle_clear),
    .increment_across (increment_across),
    .palette_write    (palette_write)
  );

  ppu_vram_access u_vram_access (
    .I_clock          (I_clock),
    .I_reset          (I_reset),
    .host_data_in     (host_data_in),
    .addr_write       (addr_write),
    .data_write       (data_write),
    .data_read        (data_read),
    .toggle_clear     (toggle_clear),
    .increment_across (increment_across),
    .vid_data_in      (vid_data_in),
    .vid_addr         (vid_addr),
    .vid_wren         (vid_wren),
    .vid_data_out     (vid_data_out),
    .read_buffer      (read_buffer),
    .palette_access   (palette_access),
    .palette_addr     (palette_addr)
  );

  ppu_palette u_palette (
    .I_clock       (I_clock),
    .I_reset       (I_reset),
    .palette_addr  (palette_addr),
    .palette_write (palette_write),
    .host_data_in  (host_data_in),
    .palette_data  (palette_data),
    .vid_red       (vid_red),
    .vid_green     (vid_green),
    .vid_blue      (vid_blue)
  );

endmodule

/* logic/ppu_palette.sv */
`timescale 1ns/1ps

module ppu_palette (
  input  logic                    I_clock,
  input  logic                    I_reset,
  input  ppu_pkg::palette_index_t palette_addr,
  input  logic                    palette_write,
  input  ppu_pkg::host_data_t     host_data_in,
  output ppu_pkg::color_index_t   palette_data,
  output ppu_pkg::color_t         vid_red,
  output ppu_pkg::color_t         vid_green,
  output ppu_pkg::color_t         vid_blue
);

  import ppu_pkg::*;

  `include "ppu_color_table.svh"

  color_index_t   palette_ram [0:31];
  palette_index_t ram_addr;
  logic [23:0]    backdrop_rgb;

  // Entries 16, 20, 24 and 28 share storage with 0, 4, 8 and 12
  always_comb
  begin
    ram_addr = palette_addr;
    if (palette_addr[1:0] == 2'b00)
      ram_addr[4] = 1'b0;
  end

  assign palette_data = palette_ram[ram_addr];

  always_ff @(posedge I_clock or negedge I_reset)
  begin
    if (!I_reset)
    begin
      for (int i = 0; i < 32; i++)
        palette_ram[i] <= '0;
    end
    else if (palette_write)
      palette_ram[ram_addr] <= host_data_in[5:0];
  end

  //////////////////////////////////////////////////
  // Backdrop colour output
  //////////////////////////////////////////////////

  assign backdrop_rgb = COLOR_TABLE[palette_ram[0]];  // No rendering, entry 0 only

  always_ff @(posedge I_clock or negedge I_reset)
  begin
    if (!I_reset)
    begin
      vid_red   <= '0;
      vid_green <= '0;
      vid_blue  <= '0;
    end
    else
    begin
      vid_red   <= backdrop_rgb[23:16];
      vid_green <= backdrop_rgb[15:8];
      vid_blue  <= backdrop_rgb[7:0];
    end
  end

endmodule

/* logic/ppu_vram_access.sv */
`timescale 1ns/1ps

module ppu_vram_access (
  input  logic                    I_clock,
  input  logic                    I_reset,
  input  ppu_pkg::host_data_t     host_data_in,
  input  logic                    addr_write,
  input  logic                    data_write,
  input  logic                    data_read,
  input  logic                    toggle_clear,
  input  logic                    increment_across,
  input  ppu_pkg::host_data_t     vid_data_in,
  output ppu_pkg::vram_addr_t     vid_addr,
  output logic                    vid_wren,
  output ppu_pkg::host_data_t     vid_data_out,
  output ppu_pkg::host_data_t     read_buffer,
  output logic                    palette_access,
  output ppu_pkg::palette_index_t palette_addr
);

  import ppu_pkg::*;

  vaddr_t     vaddr;         // Current video address
  logic [5:0] taddr;         // High six bits from the first address write
  vaddr_t     addr_step;
  logic       write_toggle;  // Set between the two address writes

  assign addr_step = increment_across ? INCREMENT_ACROSS : vaddr_t'(1);

  //////////////////////////////////////////////////
  // Address registers
  //////////////////////////////////////////////////

  always_ff @(posedge I_clock or negedge I_reset)
  begin
    if (!I_reset)
      write_toggle <= 1'b0;
    else if (addr_write)
      write_toggle <= ~write_toggle;
    else if (toggle_clear)
      write_toggle <= 1'b0;
  end

  always_ff @(posedge I_clock or negedge I_reset)
  begin
    if (!I_reset)
    begin
      taddr <= '0;
      vaddr <= '0;
    end
    else if (addr_write)
    begin
      if (!write_toggle)
        taddr <= host_data_in[5:0];  // High byte first
      else
        vaddr <= {1'b0, taddr, host_data_in};
    end
    else if (data_write || data_read)
      vaddr <= vaddr + addr_step;  // Step after each data access
  end

  //////////////////////////////////////////////////
  // Memory port and read buffer
  //////////////////////////////////////////////////

  // Buffer picks up the byte at the old address
  always_ff @(posedge I_clock or negedge I_reset)
  begin
    if (!I_reset)
      read_buffer <= '0;
    else if (data_read)
      read_buffer <= vid_data_in;
  end

  assign vid_addr       = vaddr[13:0];
  assign palette_access = (vaddr[13:8] == PALETTE_PAGE);
  assign palette_addr   = vaddr[4:0];

  // Palette writes stay inside the chip
  assign vid_wren     = data_write & ~palette_access;
  assign vid_data_out = host_data_in;

endmodule

/* logic/ppu_host_regs.sv */
`timescale 1ns/1ps

module ppu_host_regs (
  input  logic                   I_clock,
  input  logic                   I_reset,
  input  ppu_pkg::host_addr_t    host_addr,
  input  ppu_pkg::host_data_t    host_data_in,
  input  logic                   host_wren,
  input  logic                   host_rden,
  input  logic                   dot_tick,
  input  ppu_pkg::raster_count_t count_x,
  input  ppu_pkg::raster_count_t count_y,
  input  logic                   palette_access,
  input  ppu_pkg::host_data_t    read_buffer,
  input  ppu_pkg::color_index_t  palette_data,
  output ppu_pkg::host_data_t    host_data_out,
  output logic                   host_nmi,
  output logic                   addr_write,
  output logic                   data_write,
  output logic                   data_read,
  output logic                   toggle_clear,
  output logic                   increment_across,
  output logic                   palette_write
);

  import ppu_pkg::*;

  logic       last_wren;
  logic       last_rden;
  logic       wren_rise;
  logic       rden_rise;
  logic       rden_fall;
  logic       sel_control;
  logic       sel_status;
  logic       sel_addr;
  logic       sel_data;
  logic       nmi_enable;
  logic       vblank;
  host_data_t bus_latch;  // Open bus, last byte written

  //////////////////////////////////////////////////
  // Strobe edges and decode
  //////////////////////////////////////////////////

  always_ff @(posedge I_clock or negedge I_reset)
  begin
    if (!I_reset)
    begin
      last_wren <= 1'b0;
      last_rden <= 1'b0;
    end
    else
    begin
      last_wren <= host_wren;
      last_rden <= host_rden;
    end
  end

  assign wren_rise = host_wren & ~last_wren;
  assign rden_rise = host_rden & ~last_rden;
  assign rden_fall = ~host_rden & last_rden;

  assign sel_control = (host_addr == REG_CONTROL);
  assign sel_status  = (host_addr == REG_STATUS);
  assign sel_addr    = (host_addr == REG_ADDR);
  assign sel_data    = (host_addr == REG_DATA);

  // Single-cycle requests toward the VRAM side
  assign addr_write    = wren_rise & sel_addr;
  assign data_write    = wren_rise & sel_data;
  assign data_read     = rden_rise & sel_data;
  assign toggle_clear  = rden_rise & sel_status;
  assign palette_write = data_write & palette_access;

  // Control register and open bus
  always_ff @(posedge I_clock or negedge I_reset)
  begin
    if (!I_reset)
    begin
      nmi_enable       <= 1'b0;
      increment_across <= 1'b0;
      bus_latch        <= '0;
    end
    else if (wren_rise)
    begin
      bus_latch <= host_data_in;  // Any register write
      if (sel_control)
      begin
        nmi_enable       <= host_data_in[7];
        increment_across <= host_data_in[2];
      end
    end
  end

  //////////////////////////////////////////////////
  // Vertical blank and NMI
  //////////////////////////////////////////////////

  always_ff @(posedge I_clock or negedge I_reset)
  begin
    if (!I_reset)
      vblank <= 1'b0;
    else
    begin
      if (dot_tick && (count_x == '0))
      begin
        if (count_y == VBLANK_LINE)
          vblank <= 1'b1;
        else if (count_y == PRERENDER_LINE)
          vblank <= 1'b0;
      end
      if (rden_fall && sel_status)
        vblank <= 1'b0;  // Cleared once the host has seen it
    end
  end

  assign host_nmi = ~(nmi_enable & vblank);

  // Read data, undriven bits come from the latch
  always_comb
  begin
    host_data_out = bus_latch;
    case (host_addr)
      REG_STATUS:
        host_data_out = {vblank, 2'b00, bus_latch[4:0]};
      REG_DATA:
        if (palette_access)
          host_data_out = {bus_latch[7:6], palette_data};
        else
          host_data_out = read_buffer;
      default: ;
    endcase
  end

endmodule

/* logic/ppu_dot_timing.sv */
`timescale 1ns/1ps

module ppu_dot_timing #(
  parameter int CLOCK_DIV_BITS = 2
) (
  input  logic                   I_clock,
  input  logic                   I_reset,
  output logic                   vid_clock,
  output logic                   vid_rise,
  output logic                   vid_active,
  output logic                   vid_hsync,
  output logic                   vid_vsync,
  output ppu_pkg::raster_count_t count_x,
  output ppu_pkg::raster_count_t count_y
);

  import ppu_pkg::*;

  logic [CLOCK_DIV_BITS-1:0] clock_div;
  logic                      last_vid_clock;

  //////////////////////////////////////////////////
  // Dot clock
  //////////////////////////////////////////////////

  assign vid_clock = ~clock_div[CLOCK_DIV_BITS-1];  // High for the first half
  assign vid_rise  = vid_clock & ~last_vid_clock;   // One pulse per dot

  always_ff @(posedge I_clock or negedge I_reset)
  begin
    if (!I_reset)
    begin
      clock_div      <= '0;
      last_vid_clock <= 1'b0;
    end
    else
    begin
      clock_div      <= clock_div + 1'b1;
      last_vid_clock <= vid_clock;
    end
  end

  //////////////////////////////////////////////////
  // Raster counters
  //////////////////////////////////////////////////

  always_ff @(posedge I_clock or negedge I_reset)
  begin
    if (!I_reset)
    begin
      count_x <= '0;
      count_y <= '0;
    end
    else if (vid_rise)
    begin
      if (count_x == DOTS_PER_LINE - 1'b1)
      begin
        count_x <= '0;
        if (count_y == LINES_PER_FRAME - 1'b1)
          count_y <= '0;  // Wrap after the pre-render line
        else
          count_y <= count_y + 1'b1;
      end
      else
        count_x <= count_x + 1'b1;
    end
  end

  // Syncs are active low inside their windows
  assign vid_hsync = (count_x < HSYNC_FIRST) || (count_x > HSYNC_LAST);
  assign vid_vsync = (count_y < VSYNC_FIRST) || (count_y > VSYNC_LAST);

  // Dot 0 is idle, so the picture spans dots 1 to 256
  assign vid_active = (count_x != '0) && (count_x <= ACTIVE_DOTS) &&
                      (count_y < ACTIVE_LINES);

endmodule

/* logic/ppu_pkg.sv */
package ppu_pkg;

  //////////////////////////////////////////////////
  // Bus and address widths
  //////////////////////////////////////////////////

  typedef logic [7:0]  host_data_t;     // Host data byte
  typedef logic [2:0]  host_addr_t;     // Register select
  typedef logic [13:0] vram_addr_t;     // External video memory address
  typedef logic [14:0] vaddr_t;         // Internal video address register
  typedef logic [8:0]  raster_count_t;  // Dot or line count
  typedef logic [4:0]  palette_index_t;
  typedef logic [5:0]  color_index_t;
  typedef logic [7:0]  color_t;         // One RGB channel

  //////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////

  localparam host_addr_t REG_CONTROL = 3'd0;
  localparam host_addr_t REG_STATUS  = 3'd2;
  localparam host_addr_t REG_ADDR    = 3'd6;
  localparam host_addr_t REG_DATA    = 3'd7;

  //////////////////////////////////////////////////
  // Raster geometry
  //////////////////////////////////////////////////

  localparam raster_count_t DOTS_PER_LINE   = 9'd341;
  localparam raster_count_t LINES_PER_FRAME = 9'd262;
  localparam raster_count_t VBLANK_LINE     = 9'd241;
  localparam raster_count_t PRERENDER_LINE  = 9'd261;
  localparam raster_count_t ACTIVE_DOTS     = 9'd256;
  localparam raster_count_t ACTIVE_LINES    = 9'd240;

  // Sync windows, inclusive at both ends
  localparam raster_count_t HSYNC_FIRST = 9'd275;
  localparam raster_count_t HSYNC_LAST  = 9'd300;
  localparam raster_count_t VSYNC_FIRST = 9'd242;
  localparam raster_count_t VSYNC_LAST  = 9'd244;

  // Upper address bits 13:8 that map onto palette RAM
  localparam logic [5:0] PALETTE_PAGE = 6'b111111;

  localparam vaddr_t INCREMENT_ACROSS = 15'd32;  // One row of tiles

endpackage

/* logic/ppu_color_table.svh */
`ifndef PPU_COLOR_TABLE_SVH
`define PPU_COLOR_TABLE_SVH

// RGB for each 6-bit colour number, four brightness rows of 16
localparam logic [23:0] COLOR_TABLE [0:63] = '{
  24'h666666, 24'h002a88, 24'h1412a7, 24'h3b00a4,
  24'h5c007e, 24'h6e0040, 24'h6c0600, 24'h561d00,
  24'h333500, 24'h0b4800, 24'h005200, 24'h004f08,
  24'h00404d, 24'h000000, 24'h000000, 24'h000000,
  24'hadadad, 24'h155fd9, 24'h4240ff, 24'h7527fe,
  24'ha01acc, 24'hb71e7b, 24'hb53120, 24'h994e00,
  24'h6b6d00, 24'h388700, 24'h0c9300, 24'h008f32,
  24'h007c8d, 24'h000000, 24'h000000, 24'h000000,
  24'hfffeff, 24'h64b0ff, 24'h9290ff, 24'hc676ff,
  24'hf36aff, 24'hfe6ecc, 24'hfe8170, 24'hea9e22,
  24'hbcbe00, 24'h88d800, 24'h5ce430, 24'h45e082,
  24'h48cdde, 24'h4f4f4f, 24'h000000, 24'h000000,
  24'hfffeff, 24'hc0dfff, 24'hd3d2ff, 24'he8c8ff,
  24'hfbc2ff, 24'hfec4ea, 24'hfeccc5, 24'hf7d8a5,
  24'he4e594, 24'hcfef96, 24'hbdf4ab, 24'hb3f3cc,
  24'hb5ebf2, 24'hb8b8b8, 24'h000000, 24'h000000
};

`endif
